/* source/blur_pkg.sv */
package blur_pkg;

    // RGB444 pixel with red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] pixel_t;
    typedef logic [3:0]  chan_t;

    // Position of a pixel inside the frame
    typedef logic [9:0] col_t;
    typedef logic [8:0] row_t;

    // Red, green, blue
    localparam int NUM_CHANS = 3;

    // Kernel geometry
    localparam int KERN_ROWS = 5;
    localparam int KERN_COLS = 7;
    localparam int KERN_TAPS = KERN_ROWS * KERN_COLS;

    // Weights sum to 64, so normalize by a shift of six
    localparam int NORM_SHIFT = 6;
    localparam int SUM_W      = 10;
    typedef logic [SUM_W-1:0] blur_sum_t;

    // Tap index is row * KERN_COLS + col, row 0 is the oldest line
    typedef chan_t [KERN_TAPS-1:0] window_t;

    // Weight entry: bit 2 flags a zero weight, bits 1:0 hold log2 of the weight
    typedef logic [2:0] shift_entry_t;
    localparam int ZERO_BIT = 2;

    localparam shift_entry_t WT_0 = 3'b100;
    localparam shift_entry_t WT_1 = 3'b000;
    localparam shift_entry_t WT_2 = 3'b001;
    localparam shift_entry_t WT_4 = 3'b010;

    // One kernel row per line, oldest line first
    localparam shift_entry_t BLUR_SHIFT [KERN_TAPS] = '{
        WT_0, WT_1, WT_1, WT_1, WT_2, WT_2, WT_2,
        WT_0, WT_1, WT_1, WT_2, WT_2, WT_2, WT_2,
        WT_1, WT_1, WT_2, WT_2, WT_2, WT_2, WT_2,
        WT_1, WT_2, WT_2, WT_2, WT_2, WT_2, WT_4,
        WT_2, WT_2, WT_2, WT_2, WT_2, WT_4, WT_4
    };

    // Blur only strictly inside these bounds
    localparam col_t BORDER_COLS = 7;
    localparam row_t BORDER_ROWS = 5;

endpackage

/* source/pixel_window.sv */
module pixel_window
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH  = 320,
    parameter int IMG_HEIGHT = 240
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    ready_in,
    input  logic    valid_in,
    input  logic    startofpacket_in,
    input  pixel_t  data_in,
    output logic    accept,
    output col_t    col,
    output row_t    row,
    output window_t red_win,
    output window_t green_win,
    output window_t blue_win
);

    // Four full lines plus one kernel width
    localparam int DEPTH = (KERN_ROWS - 1) * IMG_WIDTH + KERN_COLS;
    localparam int CHAN_W = $bits(chan_t);

    // Channel 0 is red, taken from the top nibble
    chan_t chan_in [NUM_CHANS];

    // Index 0 holds the oldest pixel, DEPTH-1 the newest
    chan_t chan_sr [NUM_CHANS][DEPTH];

    window_t chan_win [NUM_CHANS];

    // Position for the next pixel
    col_t col_q;
    row_t row_q;

    // A beat moves only with both strobes high
    assign accept = ready_in && valid_in;

    // Start of packet puts this beat at the frame origin
    assign col = startofpacket_in ? '0 : col_q;
    assign row = startofpacket_in ? '0 : row_q;

    always_comb begin
        for (int c = 0; c < NUM_CHANS; c++) begin
            chan_in[c] = data_in[(NUM_CHANS - 1 - c) * CHAN_W +: CHAN_W];
        end
    end

    // Column and row counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (accept) begin
            // Last column of a line, move to the next row
            if (col == col_t'(IMG_WIDTH - 1)) begin
                col_q <= '0;
                row_q <= row + 1'b1;
            end else begin
                col_q <= col + 1'b1;
                row_q <= row;
            end
        end
    end

    // Shift register per channel, advanced once per accepted beat
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < NUM_CHANS; c++) begin
                for (int k = 0; k < DEPTH; k++) begin
                    chan_sr[c][k] <= '0;
                end
            end
        end else if (accept) begin
            for (int c = 0; c < NUM_CHANS; c++) begin
                for (int k = 0; k < DEPTH - 1; k++) begin
                    chan_sr[c][k] <= chan_sr[c][k+1];
                end
                // Newest pixel enters at the top end
                chan_sr[c][DEPTH-1] <= chan_in[c];
            end
        end
    end

    // Kernel taps, one image line apart per kernel row
    for (genvar c = 0; c < NUM_CHANS; c++) begin : g_chan
        for (genvar i = 0; i < KERN_ROWS; i++) begin : g_row
            for (genvar j = 0; j < KERN_COLS; j++) begin : g_col
                assign chan_win[c][i * KERN_COLS + j] = chan_sr[c][i * IMG_WIDTH + j];
            end
        end
    end

    assign red_win   = chan_win[0];
    assign green_win = chan_win[1];
    assign blue_win  = chan_win[2];

    // Column counter wraps before reaching the line width
    a_col_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        col_q < col_t'(IMG_WIDTH)
    );

    // Every accepted pixel lies inside the frame height
    a_row_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        accept |-> (row < row_t'(IMG_HEIGHT))
    );

endmodule

/* source/channel_blur.sv */
module channel_blur
    import blur_pkg::*;
(
    // Used only to sample the range check
    input  logic    clk,
    input  window_t win,
    output chan_t   blurred
);

    // Two spare bits so an overflow would stay visible
    localparam int FULL_W = SUM_W + 2;

    // Brightest channel value times the full weight
    localparam int MAX_SUM = ((2 ** $bits(chan_t)) - 1) << NORM_SHIFT;

    logic [FULL_W-1:0] sum_full;
    blur_sum_t         sum;

    // Weighted sum, each weight is a power of two
    always_comb begin
        sum_full = '0;
        for (int t = 0; t < KERN_TAPS; t++) begin
            // Zero weights contribute nothing
            if (!BLUR_SHIFT[t][ZERO_BIT]) begin
                sum_full = sum_full
                         + (FULL_W'(win[t]) << BLUR_SHIFT[t][ZERO_BIT-1:0]);
            end
        end
    end

    assign sum = sum_full[SUM_W-1:0];

    // Divide by 64, upper four bits of the accumulator
    assign blurred = sum[SUM_W-1:NORM_SHIFT];

    // Weights of 64 keep the sum within a full-scale channel times 64
    a_sum_range : assert property (
        @(posedge clk)
        sum_full <= FULL_W'(MAX_SUM)
    );

endmodule

/* source/pixel_output.sv */
module pixel_output
    import blur_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   accept,
    input  col_t   col,
    input  row_t   row,
    input  chan_t  red_blur,
    input  chan_t  green_blur,
    input  chan_t  blue_blur,
    input  pixel_t data_in,
    output pixel_t data_out
);

    logic   use_blur;
    pixel_t blur_word;

    // Window only holds valid frame data past the border
    assign use_blur = (col > BORDER_COLS) && (row > BORDER_ROWS);

    // Repack in RGB444 order
    assign blur_word = {red_blur, green_blur, blue_blur};

    // Output word, updated once per accepted beat
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (accept) begin
            if (use_blur) begin
                data_out <= blur_word;
            end else begin
                // Border pixels pass through raw
                data_out <= data_in;
            end
        end
    end

    // Output holds across stalled cycles
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$past(accept) |-> $stable(data_out)
    );

endmodule

/* source/blurring_filter.sv */
module blurring_filter
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH  = 320,
    parameter int IMG_HEIGHT = 240
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   ready_in,
    input  logic   valid_in,
    input  logic   startofpacket_in,
    input  logic   endofpacket_in,
    input  pixel_t data_in,
    output logic   ready_out,
    output logic   valid_out,
    output logic   startofpacket_out,
    output logic   endofpacket_out,
    output pixel_t data_out
);

    logic    accept;
    col_t    col;
    row_t    row;

    // Per-channel windows and results, index 0 is red
    window_t chan_win  [NUM_CHANS];
    chan_t   chan_blur [NUM_CHANS];

    // Strobes pass straight through
    assign ready_out         = ready_in;
    assign valid_out         = valid_in;
    assign startofpacket_out = startofpacket_in;
    assign endofpacket_out   = endofpacket_in;

    // Line buffer window and position tracking
    pixel_window #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_window (
        .clk              (clk),
        .arst_n           (arst_n),
        .ready_in         (ready_in),
        .valid_in         (valid_in),
        .startofpacket_in (startofpacket_in),
        .data_in          (data_in),
        .accept           (accept),
        .col              (col),
        .row              (row),
        .red_win          (chan_win[0]),
        .green_win        (chan_win[1]),
        .blue_win         (chan_win[2])
    );

    // Same kernel on every channel
    for (genvar c = 0; c < NUM_CHANS; c++) begin : g_blur
        channel_blur u_blur (
            .clk     (clk),
            .win     (chan_win[c]),
            .blurred (chan_blur[c])
        );
    end

    // Border select and output register
    pixel_output u_output (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .col        (col),
        .row        (row),
        .red_blur   (chan_blur[0]),
        .green_blur (chan_blur[1]),
        .blue_blur  (chan_blur[2]),
        .data_in    (data_in),
        .data_out   (data_out)
    );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    // Free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* sim/blurring_filter_tb.sv */
module blurring_filter_tb
    import blur_pkg::*;
();

    // Small frame keeps the run short
    localparam int IMG_WIDTH  = 32;
    localparam int IMG_HEIGHT = 16;

    // Full frame, then a frame cut after ten lines and thirteen pixels
    localparam int FRAME_BEATS    = IMG_WIDTH * IMG_HEIGHT;
    localparam int CUT_BEATS      = 10 * IMG_WIDTH + 13;
    localparam int TOTAL_BEATS    = 2 * FRAME_BEATS + CUT_BEATS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS + 1000;

    // Distance from the oldest window tap to the current beat
    localparam int SPAN = 4 * IMG_WIDTH + 7;

    // Last column and row that stay unblurred
    localparam int EDGE_COLS = 7;
    localparam int EDGE_ROWS = 5;

    // Kernel weights, oldest line first
    localparam int WEIGHTS [5][7] = '{
        '{0, 1, 1, 1, 2, 2, 2},
        '{0, 1, 1, 2, 2, 2, 2},
        '{1, 1, 2, 2, 2, 2, 2},
        '{1, 2, 2, 2, 2, 2, 4},
        '{2, 2, 2, 2, 2, 4, 4}
    };

    logic   clk;
    logic   arst_n;
    logic   ready_in;
    logic   valid_in;
    logic   startofpacket_in;
    logic   endofpacket_in;
    pixel_t data_in;
    logic   ready_out;
    logic   valid_out;
    logic   startofpacket_out;
    logic   endofpacket_out;
    pixel_t data_out;

    logic [31:0] seed;

    // Every accepted pixel since reset, in acceptance order
    pixel_t hist [TOTAL_BEATS];
    int     beat_count;
    int     model_col;
    int     model_row;
    logic   restarted;

    // Expected output for the beat accepted on the last edge
    pixel_t exp_word;
    pixel_t exp_raw;
    logic   chk_border;
    logic   chk_interior;
    logic   chk_hold;
    logic   chk_restart;
    logic   seen_accept;

    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (8)
    ) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    blurring_filter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) DUT (
        .clk               (clk),
        .arst_n            (arst_n),
        .ready_in          (ready_in),
        .valid_in          (valid_in),
        .startofpacket_in  (startofpacket_in),
        .endofpacket_in    (endofpacket_in),
        .data_in           (data_in),
        .ready_out         (ready_out),
        .valid_out         (valid_out),
        .startofpacket_out (startofpacket_out),
        .endofpacket_out   (endofpacket_out),
        .data_out          (data_out)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Channel 0 is red in the top nibble
    function automatic logic [3:0] nibble_of(input pixel_t pix, input int ch);
        case (ch)
            0:       return pix[11:8];
            1:       return pix[7:4];
            default: return pix[3:0];
        endcase
    endfunction

    // Weighted sum over the 35 history pixels behind beat p, divided by 64
    function automatic pixel_t blurred_word(input int p);
        int     sum;
        int     idx;
        pixel_t word;
        word = '0;
        for (int ch = 0; ch < 3; ch++) begin
            sum = 0;
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 7; j++) begin
                    idx = p - SPAN + i * IMG_WIDTH + j;
                    // Pixels from before reset read as zero
                    if (idx >= 0) begin
                        sum = sum + WEIGHTS[i][j] * int'(nibble_of(hist[idx], ch));
                    end
                end
            end
            word[(2 - ch) * 4 +: 4] = 4'(sum / 64);
        end
        return word;
    endfunction

    task automatic report_value(input string test_name, input pixel_t expected,
                                input pixel_t actual);
        $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check %s failed", test_name);
    endtask

    task automatic report_plain(input string what);
        $display("ERROR: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    // One beat, sometimes preceded by a cycle with valid or ready low
    task automatic send_beat(input logic sop, input logic eop);
        seed = lcg_step(seed);
        if (seed[31:30] == 2'b00) begin
            @(posedge clk);
            // Never both high, so the stall beat is never accepted
            valid_in         <= seed[6] && !seed[5];
            ready_in         <= seed[5] && !seed[6];
            startofpacket_in <= seed[7];
            endofpacket_in   <= seed[8];
            data_in          <= seed[20:9];
            seed = lcg_step(seed);
        end
        @(posedge clk);
        valid_in         <= 1'b1;
        ready_in         <= 1'b1;
        startofpacket_in <= sop;
        endofpacket_in   <= eop;
        data_in          <= seed[27:16];
    endtask

    task automatic send_frame(input int n_beats, input logic with_eop);
        for (int b = 0; b < n_beats; b++) begin
            send_beat(b == 0, with_eop && (b == n_beats - 1));
        end
    endtask

    // Reference model, updated on every accepted beat
    always @(posedge clk) begin : model_update
        logic border;
        if (!arst_n) begin
            beat_count = 0;
            model_col  = 0;
            model_row  = 0;
            restarted  = 1'b0;
            exp_word     <= '0;
            exp_raw      <= '0;
            chk_border   <= 1'b0;
            chk_interior <= 1'b0;
            chk_hold     <= 1'b0;
            chk_restart  <= 1'b0;
            seen_accept  <= 1'b0;
        end else if (ready_in && valid_in) begin
            if (startofpacket_in) begin
                // A start of packet inside an unfinished frame
                restarted = (model_row < IMG_HEIGHT) && ((model_col != 0) || (model_row != 0));
                model_col = 0;
                model_row = 0;
            end
            hist[beat_count] = data_in;
            border = (model_col <= EDGE_COLS) || (model_row <= EDGE_ROWS);
            if (border) begin
                exp_word <= data_in;
            end else begin
                exp_word <= blurred_word(beat_count);
            end
            exp_raw      <= data_in;
            chk_border   <= border;
            chk_interior <= !border;
            chk_hold     <= 1'b0;
            chk_restart  <= restarted && (model_row <= EDGE_ROWS) && (model_col <= EDGE_COLS);
            seen_accept  <= 1'b1;
            beat_count++;
            if (model_col == IMG_WIDTH - 1) begin
                model_col = 0;
                model_row++;
            end else begin
                model_col++;
            end
        end else begin
            // Stalled cycle, the model keeps its last word
            chk_border   <= 1'b0;
            chk_interior <= 1'b0;
            chk_restart  <= 1'b0;
            chk_hold     <= 1'b1;
        end
    end

    a_reset_zero : assert property (
        @(posedge clk) disable iff (!arst_n)
        !seen_accept |-> (data_out == '0)
    ) else report_value("reset value", '0, $sampled(data_out));

    a_strobes : assert property (
        @(posedge clk)
        {ready_out, valid_out, startofpacket_out, endofpacket_out}
            == {ready_in, valid_in, startofpacket_in, endofpacket_in}
    ) else report_value("strobe pass-through",
        pixel_t'($sampled({ready_in, valid_in, startofpacket_in, endofpacket_in})),
        pixel_t'($sampled({ready_out, valid_out, startofpacket_out, endofpacket_out})));

    a_border : assert property (
        @(posedge clk) disable iff (!arst_n)
        chk_border |-> (data_out == exp_word)
    ) else report_value("border passthrough", $sampled(exp_word), $sampled(data_out));

    a_interior : assert property (
        @(posedge clk) disable iff (!arst_n)
        chk_interior |-> (data_out == exp_word)
    ) else report_value("interior blur", $sampled(exp_word), $sampled(data_out));

    // Held word equals the last expected word
    a_hold : assert property (
        @(posedge clk) disable iff (!arst_n)
        chk_hold |-> (data_out == exp_word)
    ) else report_value("back-pressure hold", $sampled(exp_word), $sampled(data_out));

    a_restart : assert property (
        @(posedge clk) disable iff (!arst_n)
        chk_restart |-> (data_out == exp_raw)
    ) else report_value("frame restart", $sampled(exp_raw), $sampled(data_out));

    // Run limit from the beat count, stalls at most double it
    always @(posedge clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_plain("simulation did not finish within the cycle limit");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        seed = 32'h1a53201b;
        ready_in         <= 1'b0;
        valid_in         <= 1'b0;
        startofpacket_in <= 1'b0;
        endofpacket_in   <= 1'b0;
        data_in          <= '0;
        @(posedge clk);
        while (!arst_n) begin
            @(posedge clk);
        end
        // Idle cycles with the output still at its reset value
        repeat (3) @(posedge clk);
        send_frame(FRAME_BEATS, 1'b1);
        send_frame(CUT_BEATS, 1'b0);
        send_frame(FRAME_BEATS, 1'b1);
        @(posedge clk);
        valid_in         <= 1'b0;
        ready_in         <= 1'b0;
        startofpacket_in <= 1'b0;
        endofpacket_in   <= 1'b0;
        // Model counts on the rising edge, read it between edges
        while (beat_count < TOTAL_BEATS) begin
            @(negedge clk);
        end
        // One cycle of latency, then a stalled cycle
        repeat (2) @(posedge clk);
        // Half a cycle past the last checked edge
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* files.f */
source/blur_pkg.sv
source/pixel_window.sv
source/channel_blur.sv
source/pixel_output.sv
source/blurring_filter.sv
sim/tb_clock_gen.sv
sim/blurring_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module blurring_filter_tb \
    -Mdir obj_dir -o sim_top \
    && ./obj_dir/sim_top > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
